//--- hdl/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch
    import fetch_pkg::*;
#(
    parameter int NUM_MEM_TAGS      = 15,
    parameter int PREFETCH_DISTANCE = 3,
    parameter int ICACHE_LINES      = 32,
    parameter int IBUFF_DEPTH       = 16
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  addr_t                                target,
    input  br_task_e                             br_task,
    input  logic                                 mem_grant,
    input  mem_tag_t                             mem_transaction_tag,
    input  mem_tag_t                             mem_data_tag,
    input  mem_block_t                           mem_data,
    input  logic [$clog2(IBUFF_DEPTH+1)-1:0]     ibuff_open,
    output logic                                 mem_en,
    output addr_t                                mem_addr,
    output inst_packet_t [3:0]                   out_insts,
    output logic [2:0]                           out_num_insts
);

    logic  squash;
    addr_t fetch_pc;
    addr_t npc;

    // cache side
    mem_block_t [PREFETCH_DISTANCE-1:0] cache_data;
    logic       [PREFETCH_DISTANCE-1:0] cache_valid;
    logic                               fill_en;
    addr_t                              fill_addr;
    mem_block_t                         fill_data;

    // next group
    inst_packet_t [3:0] next_insts;
    logic [2:0]         next_num;
    addr_t              next_pc;

    assign squash = (br_task == br_squash);
    // redirect takes effect in the same cycle for lookups and requests
    assign npc = squash ? target : fetch_pc;

    icache #(
        .ICACHE_LINES      (ICACHE_LINES),
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE)
    ) icache_0 (
        .clock      (clock),
        .reset      (reset),
        .read_addr  (npc),
        .fill_en    (fill_en),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data),
        .read_data  (cache_data),
        .read_valid (cache_valid)
    );

    fetch_mshr #(
        .NUM_MEM_TAGS      (NUM_MEM_TAGS),
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE)
    ) fetch_mshr_0 (
        .clock               (clock),
        .reset               (reset),
        .npc                 (npc),
        .block_valid         (cache_valid),
        .mem_grant           (mem_grant),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .fill_en             (fill_en),
        .fill_addr           (fill_addr),
        .fill_data           (fill_data)
    );

    always_comb begin
        int avail;
        int room;
        int send;
        int w;
        logic chain;
        // instructions in the run of hit blocks starting at npc
        avail = 0;
        chain = 1'b1;
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            chain = chain && cache_valid[i];
            if (chain) begin
                // odd word start only gets the upper half of block 0
                avail = avail + (((i == 0) && npc[2]) ? 1 : 2);
            end
        end
        // group still in flight to the buffer counts against its space
        room = int'(ibuff_open) - int'(out_num_insts);
        if (room < 0) begin
            room = 0;
        end
        send = (avail < 4) ? avail : 4;
        send = (send < room) ? send : room;
        next_num = 3'(send);
        next_pc  = npc + addr_t'(send * 4);
        // pack in program order
        // w is the word offset from the block of npc
        next_insts = '0;
        for (int k = 0; k < 4; k++) begin
            w = k + int'(npc[2]);
            if (k < send) begin
                next_insts[k].valid = 1'b1;
                next_insts[k].pc    = npc + addr_t'(k * 4);
                next_insts[k].npc   = npc + addr_t'(k * 4 + 4);
                next_insts[k].inst  = cache_data[w / 2].word_level[w % 2];
            end
        end
    end

    // squash drops the group and restarts at the target
    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc      <= '0;
            out_num_insts <= '0;
        end else if (squash) begin
            fetch_pc      <= target;
            out_num_insts <= '0;
        end else begin
            fetch_pc      <= next_pc;
            out_num_insts <= next_num;
        end
    end

    // group payload for the buffer
    always_ff @(posedge clock) begin
        out_insts <= next_insts;
    end

endmodule

`default_nettype wire

//--- hdl/fetch_mshr.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_mshr
    import fetch_pkg::*;
#(
    parameter int NUM_MEM_TAGS      = 15,
    parameter int PREFETCH_DISTANCE = 3
) (
    input  logic                         clock,
    input  logic                         reset,
    input  addr_t                        npc,
    input  logic [PREFETCH_DISTANCE-1:0] block_valid,
    input  logic                         mem_grant,
    input  mem_tag_t                     mem_transaction_tag,
    input  mem_tag_t                     mem_data_tag,
    input  mem_block_t                   mem_data,
    output logic                         mem_en,
    output addr_t                        mem_addr,
    output logic                         fill_en,
    output addr_t                        fill_addr,
    output mem_block_t                   fill_data
);

    // one entry per memory tag, tag 0 is never handed out
    addr_t [NUM_MEM_TAGS:1] mshr_addr;
    logic  [NUM_MEM_TAGS:1] mshr_valid;

    logic  need_req;
    addr_t req_addr;
    logic  req_accept;
    logic  resp_hit;

    // response for a tag we are actually waiting on
    assign resp_hit = (mem_data_tag != '0) && (int'(mem_data_tag) <= NUM_MEM_TAGS)
                      && mshr_valid[mem_data_tag];

    // returned block goes straight into the cache
    assign fill_en   = resp_hit;
    assign fill_addr = mshr_addr[mem_data_tag];
    assign fill_data = mem_data;

    // first block from npc onward that is missing and not yet in flight
    always_comb begin
        addr_t blk;
        logic  in_flight;
        need_req = 1'b0;
        req_addr = '0;
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            blk = {npc[31:3], 3'b000} + addr_t'(i * 8);
            in_flight = 1'b0;
            for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
                if (mshr_valid[t] && (mshr_addr[t] == blk)) begin
                    in_flight = 1'b1;
                end
            end
            if (!need_req && !block_valid[i] && !in_flight) begin
                need_req = 1'b1;
                req_addr = blk;
            end
        end
    end

    // one request per cycle, only while the arbiter grants the port
    assign mem_en     = need_req && mem_grant && !reset;
    assign mem_addr   = req_addr;
    // tag 0 means memory turned the request down
    assign req_accept = mem_en && (mem_transaction_tag != '0);

    // allocation after free, so a recycled tag ends up valid
    always_ff @(posedge clock) begin
        if (reset) begin
            mshr_valid <= '0;
        end else begin
            if (resp_hit) begin
                mshr_valid[mem_data_tag] <= 1'b0;
            end
            if (req_accept) begin
                mshr_valid[mem_transaction_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (req_accept) begin
            mshr_addr[mem_transaction_tag] <= req_addr;
        end
    end

    // memory must not grant a tag still outstanding here, unless it retires now
    tag_not_busy: assert property (
        @(posedge clock) disable iff (reset)
        req_accept |-> (!mshr_valid[mem_transaction_tag]
                        || (resp_hit && (mem_data_tag == mem_transaction_tag)))
    );

endmodule

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // byte address, word aligned for instructions
    typedef logic [31:0] addr_t;

    // one raw instruction word
    typedef logic [31:0] inst_t;

    // one memory block holds two instructions
    // word 0 sits at the lower address
    typedef struct packed {
        inst_t [1:0] word_level;
    } mem_block_t;

    // split-transaction tag, zero means no tag
    typedef logic [3:0] mem_tag_t;

    // branch outcome reported back to fetch
    // only br_squash redirects, br_clear means the prediction held
    typedef enum logic [1:0] {
        br_none   = 2'd0,
        br_clear  = 2'd1,
        br_squash = 2'd2
    } br_task_e;

    // one fetched instruction on its way to the buffer
    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t npc;
        inst_t inst;
    } inst_packet_t;

endpackage

`default_nettype wire

//--- hdl/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top
    import fetch_pkg::*;
#(
    parameter int NUM_MEM_TAGS      = 15,
    parameter int PREFETCH_DISTANCE = 3,
    parameter int ICACHE_LINES      = 32,
    parameter int IBUFF_DEPTH       = 16
) (
    input  logic               clock,
    input  logic               reset,
    input  addr_t              target,
    input  br_task_e           br_task,
    input  logic               mem_grant,
    input  mem_tag_t           mem_transaction_tag,
    input  mem_tag_t           mem_data_tag,
    input  mem_block_t         mem_data,
    output logic               mem_en,
    output addr_t              mem_addr,
    input  logic [1:0]         dispatch_request,
    output inst_packet_t [1:0] dispatch_insts,
    output logic [1:0]         dispatch_count
);

    // fetch group handed to the buffer
    inst_packet_t [3:0]                 fetch_insts;
    logic [2:0]                         fetch_num;
    logic [$clog2(IBUFF_DEPTH+1)-1:0]   ibuff_open;
    logic                               flush;

    // only a squash empties the buffer
    assign flush = (br_task == br_squash);

    fetch #(
        .NUM_MEM_TAGS      (NUM_MEM_TAGS),
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE),
        .ICACHE_LINES      (ICACHE_LINES),
        .IBUFF_DEPTH       (IBUFF_DEPTH)
    ) fetch_0 (
        .clock               (clock),
        .reset               (reset),
        .target              (target),
        .br_task             (br_task),
        .mem_grant           (mem_grant),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .ibuff_open          (ibuff_open),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .out_insts           (fetch_insts),
        .out_num_insts       (fetch_num)
    );

    inst_buffer #(
        .IBUFF_DEPTH (IBUFF_DEPTH)
    ) inst_buffer_0 (
        .clock            (clock),
        .reset            (reset),
        .flush            (flush),
        .in_insts         (fetch_insts),
        .in_count         (fetch_num),
        .dispatch_request (dispatch_request),
        .dispatch_insts   (dispatch_insts),
        .dispatch_count   (dispatch_count),
        .open_count       (ibuff_open)
    );

endmodule

`default_nettype wire

//--- hdl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache
    import fetch_pkg::*;
#(
    parameter int ICACHE_LINES      = 32,
    parameter int PREFETCH_DISTANCE = 3
) (
    input  logic                                clock,
    input  logic                                reset,
    input  addr_t                               read_addr,
    input  logic                                fill_en,
    input  addr_t                               fill_addr,
    input  mem_block_t                          fill_data,
    output mem_block_t [PREFETCH_DISTANCE-1:0]  read_data,
    output logic       [PREFETCH_DISTANCE-1:0]  read_valid
);

    // 8 byte blocks, index above the block offset, tag above the index
    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = 32 - 3 - IDX_W;

    // line storage
    mem_block_t             lines [ICACHE_LINES];
    logic       [TAG_W-1:0] tags  [ICACHE_LINES];
    logic [ICACHE_LINES-1:0] line_valid;

    logic [IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] fill_tag;

    assign fill_idx = fill_addr[IDX_W+2:3];
    assign fill_tag = fill_addr[31:IDX_W+3];

    // look up the block of read_addr and the ones right after it
    always_comb begin
        addr_t            blk;
        logic [IDX_W-1:0] idx;
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            blk = {read_addr[31:3], 3'b000} + addr_t'(i * 8);
            idx = blk[IDX_W+2:3];
            read_data[i] = lines[idx];
            // hit needs a live line with a matching tag
            read_valid[i] = line_valid[idx] && (tags[idx] == blk[31:IDX_W+3]);
        end
    end

    // reset invalidates every line
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_en) begin
            line_valid[fill_idx] <= 1'b1;
        end
    end

    // fill overwrites whatever held the line before
    always_ff @(posedge clock) begin
        if (fill_en) begin
            lines[fill_idx] <= fill_data;
            tags[fill_idx]  <= fill_tag;
        end
    end

    // fills always carry a whole block
    fill_block_aligned: assert property (
        @(posedge clock) disable iff (reset)
        fill_en |-> (fill_addr[2:0] == 3'b000)
    );

endmodule

`default_nettype wire

//--- hdl/inst_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module inst_buffer
    import fetch_pkg::*;
#(
    parameter int IBUFF_DEPTH = 16
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 flush,
    input  inst_packet_t [3:0]                   in_insts,
    input  logic [2:0]                           in_count,
    input  logic [1:0]                           dispatch_request,
    output inst_packet_t [1:0]                   dispatch_insts,
    output logic [1:0]                           dispatch_count,
    output logic [$clog2(IBUFF_DEPTH+1)-1:0]     open_count
);

    localparam int PTR_W = $clog2(IBUFF_DEPTH);
    localparam int CNT_W = $clog2(IBUFF_DEPTH + 1);

    inst_packet_t entries [IBUFF_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    // pointer step with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] p, input int n);
        int s;
        s = int'(p) + n;
        if (s >= IBUFF_DEPTH) begin
            s = s - IBUFF_DEPTH;
        end
        return PTR_W'(s);
    endfunction

    assign open_count = CNT_W'(IBUFF_DEPTH) - count;

    // head entries shown straight from storage
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            dispatch_insts[k] = entries[ptr_add(head, k)];
        end
    end

    // younger than the squashing branch, so nothing leaves in a flush cycle
    always_comb begin
        if (flush) begin
            dispatch_count = 2'd0;
        end else if (int'(dispatch_request) < int'(count)) begin
            dispatch_count = dispatch_request;
        end else begin
            dispatch_count = 2'(count);
        end
    end

    // pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= ptr_add(head, int'(dispatch_count));
            tail  <= ptr_add(tail, int'(in_count));
            count <= count + CNT_W'(in_count) - CNT_W'(dispatch_count);
        end
    end

    // write the leading in_count packets at the tail
    always_ff @(posedge clock) begin
        if (!flush) begin
            for (int k = 0; k < 4; k++) begin
                if (k < int'(in_count)) begin
                    entries[ptr_add(tail, k)] <= in_insts[k];
                end
            end
        end
    end

    // fetch must respect the space reported a cycle earlier
    no_overflow: assert property (
        @(posedge clock) disable iff (reset)
        int'(in_count) <= int'(open_count)
    );

endmodule

`default_nettype wire

//--- list.f
hdl/fetch_pkg.sv
hdl/icache.sv
hdl/fetch_mshr.sv
hdl/fetch.sv
hdl/inst_buffer.sv
hdl/frontend_top.sv
tb/mem_responder.sv
tb/frontend_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module frontend_tb -f list.f -o frontend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/frontend_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" sim.log; then
    exit 0
fi
exit 1

//--- tb/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_tb
    import fetch_pkg::*;
();

    localparam int NUM_MEM_TAGS      = 15;
    localparam int PREFETCH_DISTANCE = 3;
    localparam int ICACHE_LINES      = 32;
    localparam int IBUFF_DEPTH       = 16;
    // instructions that must reach dispatch
    localparam int MIN_DISPATCH = 200;
    // full rate would need about a hundred cycles
    localparam int CYCLE_LIMIT  = 20 * MIN_DISPATCH;
    // word at address a holds a ^ WORD_KEY
    localparam logic [31:0] WORD_KEY = 32'hC0DE0000;

    logic               clock;
    logic               reset;
    addr_t              target;
    br_task_e           br_task;
    logic               mem_grant;
    mem_tag_t           mem_transaction_tag;
    mem_tag_t           mem_data_tag;
    mem_block_t         mem_data;
    logic               mem_en;
    addr_t              mem_addr;
    logic [1:0]         dispatch_request;
    inst_packet_t [1:0] dispatch_insts;
    logic [1:0]         dispatch_count;
    logic [7:0]         dice;

    // reference model
    logic [31:0] lfsr_state;
    addr_t       exp_pc;
    int          bufcnt;
    logic        pend_valid [1:NUM_MEM_TAGS];
    addr_t       pend_addr  [1:NUM_MEM_TAGS];

    // run statistics
    int errors;
    int dispatched;
    int requests;
    int squashes;
    int cycles;

    frontend_top #(
        .NUM_MEM_TAGS      (NUM_MEM_TAGS),
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE),
        .ICACHE_LINES      (ICACHE_LINES),
        .IBUFF_DEPTH       (IBUFF_DEPTH)
    ) dut0 (
        .clock               (clock),
        .reset               (reset),
        .target              (target),
        .br_task             (br_task),
        .mem_grant           (mem_grant),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .dispatch_request    (dispatch_request),
        .dispatch_insts      (dispatch_insts),
        .dispatch_count      (dispatch_count)
    );

    mem_responder #(
        .NUM_MEM_TAGS (NUM_MEM_TAGS)
    ) mem0 (
        .clock               (clock),
        .reset               (reset),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .dice                (dice),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data)
    );

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        errors++;
        $display("FAIL %s expected %h actual %h", name, expected, actual);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR %s", what);
    endtask

    // new random inputs on the falling edge
    task automatic drive_inputs();
        logic [1:0] req;
        logic [5:0] roll;
        mem_grant = (take_bits(2) != 0);
        dice      = 8'(take_bits(8));
        req       = 2'(take_bits(2));
        // two is the widest dispatch
        dispatch_request = (req == 2'd3) ? 2'd2 : req;
        roll = 6'(take_bits(6));
        // squash about once in 64 cycles to a word inside the first 1 KB
        if (roll == 6'd0) begin
            br_task = br_squash;
            target  = addr_t'(take_bits(8)) << 2;
            squashes++;
        end else if (roll[5:4] == 2'b00) begin
            br_task = br_clear;
        end else begin
            br_task = br_none;
        end
    endtask

    // runs just before the rising edge once every output has settled
    task automatic check_cycle();
        inst_packet_t pkt;
        mem_tag_t     tag;
        int           n;
        n = int'(dispatch_count);
        if (n > int'(dispatch_request)) begin
            report_value("dispatch count vs request", 32'(dispatch_request), 32'(n));
        end
        if (n > bufcnt) begin
            report_problem($sformatf("dispatched %0d but the buffer only received %0d",
                                     n, bufcnt));
        end
        // dispatched stream against the expected path
        for (int k = 0; k < 2; k++) begin
            if (k < n) begin
                pkt = dispatch_insts[k];
                if (!pkt.valid) begin
                    report_problem($sformatf("dispatched packet at pc %h is not valid", pkt.pc));
                end
                if (pkt.pc != exp_pc) begin
                    report_value("dispatch pc", exp_pc, pkt.pc);
                end
                if (pkt.inst != (pkt.pc ^ WORD_KEY)) begin
                    report_value("dispatch inst", pkt.pc ^ WORD_KEY, pkt.inst);
                end
                if (pkt.npc != (pkt.pc + 32'd4)) begin
                    report_value("dispatch npc", pkt.pc + 32'd4, pkt.npc);
                end
                // next word on the expected path
                exp_pc = exp_pc + 32'd4;
                dispatched++;
            end
        end
        // memory port
        tag = mem_transaction_tag;
        if (mem_en && !mem_grant) begin
            report_problem("memory request raised while mem_grant was low");
        end
        if (mem_en && (tag != '0)) begin
            requests++;
            if (mem_addr[2:0] != 3'b000) begin
                report_value("request alignment", {mem_addr[31:3], 3'b000}, mem_addr);
            end
            for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
                if (pend_valid[t] && (pend_addr[t] == mem_addr)) begin
                    report_problem($sformatf("block %h requested again while outstanding",
                                             mem_addr));
                end
            end
        end
        // a return closes its tag before this edge opens a new one
        if (mem_data_tag != '0) begin
            pend_valid[mem_data_tag] = 1'b0;
        end
        if (mem_en && (tag != '0)) begin
            pend_valid[tag] = 1'b1;
            pend_addr[tag]  = mem_addr;
        end
        // buffer occupancy as seen from outside
        if (br_task == br_squash) begin
            exp_pc = target;
            bufcnt = 0;
        end else begin
            bufcnt = bufcnt + int'(dut0.fetch_num) - n;
            if (bufcnt > IBUFF_DEPTH) begin
                report_problem($sformatf("instruction buffer overflowed to %0d entries",
                                         bufcnt));
            end
        end
    endtask

    initial begin
        lfsr_state       = 32'd89540;
        reset            = 1'b1;
        target           = '0;
        br_task          = br_none;
        mem_grant        = 1'b0;
        dispatch_request = 2'd0;
        dice             = 8'd0;
        exp_pc           = '0;
        bufcnt           = 0;
        errors           = 0;
        dispatched       = 0;
        requests         = 0;
        squashes         = 0;
        cycles           = 0;
        for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
            pend_valid[t] = 1'b0;
            pend_addr[t]  = '0;
        end
        // reset must keep the port and dispatch quiet even with requests pending
        for (int i = 0; i < 15; i++) begin
            @(negedge clock);
            mem_grant        = 1'b1;
            dispatch_request = 2'd2;
            #8;
            if (mem_en !== 1'b0) begin
                report_problem("mem_en raised during reset");
            end
            if (dispatch_count !== 2'd0) begin
                report_value("dispatch count in reset", 32'd0, 32'(dispatch_count));
            end
        end
        @(negedge clock);
        reset = 1'b0;
        // random traffic until enough has been dispatched
        while ((dispatched < MIN_DISPATCH) && (cycles < CYCLE_LIMIT)) begin
            drive_inputs();
            #8;
            check_cycle();
            @(negedge clock);
            cycles++;
        end
        if (dispatched < MIN_DISPATCH) begin
            report_problem($sformatf("fetch stalled, %0d instructions dispatched in %0d cycles",
                                     dispatched, cycles));
        end
        $display("errors %0d, dispatched %0d, requests %0d, squashes %0d, cycles %0d",
                 errors, dispatched, requests, squashes, cycles);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/mem_responder.sv
`timescale 1ns/1ps
`default_nettype none

module mem_responder
    import fetch_pkg::*;
#(
    parameter int NUM_MEM_TAGS = 15
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       mem_en,
    input  addr_t      mem_addr,
    input  logic [7:0] dice,
    output mem_tag_t   mem_transaction_tag,
    output mem_tag_t   mem_data_tag,
    output mem_block_t mem_data
);

    // memory content is derived from the address
    localparam logic [31:0] WORD_KEY = 32'hC0DE0000;

    logic [NUM_MEM_TAGS:1] busy;
    addr_t                 addr_of [1:NUM_MEM_TAGS];
    logic [7:0]            dice_q;

    function automatic mem_block_t block_at(input addr_t a);
        mem_block_t b;
        b.word_level[0] = a ^ WORD_KEY;
        b.word_level[1] = (a + 32'd4) ^ WORD_KEY;
        return b;
    endfunction

    initial begin
        mem_transaction_tag = '0;
        mem_data_tag        = '0;
        mem_data            = '0;
    end

    // transactions open and close on the rising edge, same as the MSHRs
    always @(posedge clock) begin
        dice_q <= dice;
        if (reset) begin
            busy <= '0;
        end else begin
            if (mem_data_tag != '0) begin
                busy[mem_data_tag] <= 1'b0;
            end
            if (mem_en && (mem_transaction_tag != '0)) begin
                busy[mem_transaction_tag]    <= 1'b1;
                addr_of[mem_transaction_tag] <= mem_addr;
            end
        end
    end

    // port outputs change only on the falling edge
    always @(negedge clock) begin
        mem_tag_t offer;
        mem_tag_t ret;
        int       t;
        offer = '0;
        ret   = '0;
        if (!reset) begin
            // lowest free tag, offered three cycles out of four
            if (dice_q[1:0] != 2'b00) begin
                for (int i = NUM_MEM_TAGS; i >= 1; i--) begin
                    if (!busy[i]) begin
                        offer = mem_tag_t'(i);
                    end
                end
            end
            // return one open tag about half the time
            // search starts at a random tag so returns come out of order
            if (dice_q[2]) begin
                for (int i = 0; i < NUM_MEM_TAGS; i++) begin
                    t = ((int'(dice_q[7:4]) + i) % NUM_MEM_TAGS) + 1;
                    if (busy[t] && (ret == '0)) begin
                        ret = mem_tag_t'(t);
                    end
                end
            end
        end
        mem_transaction_tag = offer;
        mem_data_tag        = ret;
        if (ret != '0) begin
            mem_data = block_at(addr_of[ret]);
        end else begin
            mem_data = '0;
        end
    end

endmodule

`default_nettype wire
